// File: source/qupls_isa_pkg.sv
// ISA value types, condition bit positions, opcodes, function codes and instruction formats
package qupls_isa_pkg;

	// ==============================
	// Value types
	// ==============================

	// General register and ALU data word
	typedef logic [31:0] value_t;

	// Register number as it appears in an instruction field
	typedef logic [4:0] regno_t;

	// Condition vector produced by the compare instructions
	typedef logic [7:0] cond_t;

	// Bit positions inside the condition vector, bit 0 up to bit 7
	localparam int CC_EQ = 0;
	localparam int CC_NE = 1;
	localparam int CC_LT = 2;
	localparam int CC_LE = 3;
	localparam int CC_GE = 4;
	localparam int CC_GT = 5;
	localparam int CC_BC = 6;
	localparam int CC_BS = 7;

	// ==============================
	// Opcodes and function codes
	// ==============================

	// Primary opcode in the low seven bits of every instruction
	typedef enum logic [6:0] {
		OP_R2    = 7'd2,
		OP_ADDI  = 7'd4,
		OP_CMPI  = 7'd11,
		OP_CMPUI = 7'd12
	} opcode_t;

	// Function code that selects the operation of an OP_R2 instruction
	typedef enum logic [5:0] {
		FN_ADD  = 6'd4,
		FN_SUB  = 6'd5,
		FN_AND  = 6'd8,
		FN_OR   = 6'd9,
		FN_XOR  = 6'd10,
		FN_CMP  = 6'd11,
		FN_CMPU = 6'd12
	} func_t;

	// ==============================
	// Instruction formats
	// ==============================

	// Opcode only view, used to pick the format
	typedef struct packed {
		logic [24:0] payload;
		opcode_t     opcode;
	} any_fmt_t;

	// Register to register format
	typedef struct packed {
		logic [3:0] pad;
		func_t      func;
		regno_t     rs2;
		regno_t     rs1;
		regno_t     rd;
		opcode_t    opcode;
	} r2_fmt_t;

	// Register and immediate format, the immediate is 15 bits wide
	typedef struct packed {
		logic [14:0] imm;
		regno_t      rs1;
		regno_t      rd;
		opcode_t     opcode;
	} ri_fmt_t;

	typedef union packed {
		any_fmt_t any;
		r2_fmt_t  r2;
		ri_fmt_t  ri;
	} instruction_t;

endpackage

// File: source/qupls_bus_pkg.sv
// APB request and response structs and the slave address map
package qupls_bus_pkg;

	import qupls_isa_pkg::*;

	// ==============================
	// APB signal groups
	// ==============================

	// Byte address seen by the slave
	typedef logic [11:0] apb_addr_t;

	// Everything the master drives toward the slave
	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		value_t    pwdata;
	} apb_req_t;

	// Everything the slave returns, valid while pready is high
	typedef struct packed {
		logic   pready;
		value_t prdata;
		logic   pslverr;
	} apb_rsp_t;

	// ==============================
	// Address map
	// ==============================

	// Register i lives at REG_BASE plus four times i
	localparam apb_addr_t REG_BASE = 12'h000;

	// Writing here issues an instruction, reading returns the last one issued
	localparam apb_addr_t ISSUE_ADDR = 12'h100;

endpackage

// File: source/qupls_cmp.sv
// Compare unit that builds the eight bit condition vector from two operands
`timescale 1ns/1ps

module qupls_cmp
	import qupls_isa_pkg::*;
(
	input  instruction_t ir,
	input  value_t       a,
	input  value_t       b,
	output cond_t        o
);

	// Signed compare selected, either the register or the immediate form
	logic is_signed;
	// Unsigned compare selected, either the register or the immediate form
	logic is_unsigned;

	// ==============================
	// Instruction decode
	// ==============================

	always_comb
	begin
		is_signed   = 1'b0;
		is_unsigned = 1'b0;
		case (ir.any.opcode)
		OP_R2:
			begin
				// Only the two compare functions of the R2 group matter here
				is_signed   = (ir.r2.func == FN_CMP);
				is_unsigned = (ir.r2.func == FN_CMPU);
			end
		OP_CMPI:
			is_signed = 1'b1;
		OP_CMPUI:
			is_unsigned = 1'b1;
		default:
			begin
				is_signed   = 1'b0;
				is_unsigned = 1'b0;
			end
		endcase
	end

	// ==============================
	// Condition vector
	// ==============================

	always_comb
	begin
		o = '0;
		if (is_signed)
		begin
			// Equality does not depend on the sign, so it comes only with the signed form
			o[CC_EQ] = (a == b);
			o[CC_NE] = (a != b);
			o[CC_LT] = ($signed(a) < $signed(b));
			o[CC_LE] = ($signed(a) <= $signed(b));
			o[CC_GE] = ($signed(a) >= $signed(b));
			o[CC_GT] = ($signed(a) > $signed(b));
			// Bit test, the low five bits of b pick the bit of a
			o[CC_BC] = ~a[b[4:0]];
			o[CC_BS] = a[b[4:0]];
		end
		else if (is_unsigned)
		begin
			// The unsigned form leaves equality and the bit tests at zero
			o[CC_LT] = (a < b);
			o[CC_LE] = (a <= b);
			o[CC_GE] = (a >= b);
			o[CC_GT] = (a > b);
		end
	end

endmodule

// File: source/qupls_alu.sv
// ALU with operand selection, add, subtract, logic operations and the compare unit
`timescale 1ns/1ps

module qupls_alu
	import qupls_isa_pkg::*;
(
	input  instruction_t ir,
	input  value_t       a,
	input  value_t       rb,
	output value_t       o,
	output logic         illegal
);

	// Second operand after the register or immediate choice
	value_t b;
	// Immediate field widened both ways
	value_t imm_sx;
	value_t imm_zx;
	// Condition vector from the compare unit
	cond_t  cond;

	// ==============================
	// Second operand
	// ==============================

	always_comb
	begin
		imm_sx = {{17{ir.ri.imm[14]}}, ir.ri.imm};
		imm_zx = {17'd0, ir.ri.imm};
		case (ir.any.opcode)
		OP_R2:
			b = rb;
		OP_ADDI, OP_CMPI:
			b = imm_sx;
		// Unsigned compares see the immediate as a positive number
		OP_CMPUI:
			b = imm_zx;
		default:
			b = rb;
		endcase
	end

	// The compare unit decodes the same instruction on its own
	qupls_cmp u_cmp (
		.ir (ir),
		.a  (a),
		.b  (b),
		.o  (cond)
	);

	// ==============================
	// Result select
	// ==============================

	always_comb
	begin
		o       = '0;
		illegal = 1'b0;
		case (ir.any.opcode)
		OP_R2:
			case (ir.r2.func)
			FN_ADD:
				o = a + b;
			FN_SUB:
				o = a - b;
			FN_AND:
				o = a & b;
			FN_OR:
				o = a | b;
			FN_XOR:
				o = a ^ b;
			// Compare results land in the low byte, the rest stays zero
			FN_CMP, FN_CMPU:
				o = value_t'(cond);
			default:
				illegal = 1'b1;
			endcase
		OP_ADDI:
			o = a + b;
		OP_CMPI, OP_CMPUI:
			o = value_t'(cond);
		// Any encoding outside the opcode list gets no result
		default:
			illegal = 1'b1;
		endcase
	end

endmodule

// File: source/qupls_regfile.sv
// Register file with two asynchronous read ports, one write port and r0 tied to zero
`timescale 1ns/1ps

module qupls_regfile
	import qupls_isa_pkg::*;
#(
	parameter int REGS = 32
)
(
	input  logic   clk,
	input  logic   rst,
	input  regno_t ra0,
	input  regno_t ra1,
	output value_t rd0,
	output value_t rd1,
	input  logic   we,
	input  regno_t wa,
	input  value_t wd
);

	value_t regs [REGS];

	// Register zero and numbers beyond the implemented set read as zero
	function automatic value_t read_port(input regno_t ra);
		if (ra == '0 || ra >= REGS)
			return '0;
		return regs[ra];
	endfunction

	// Both read ports follow the addresses without a clock
	always_comb
	begin
		rd0 = read_port(ra0);
		rd1 = read_port(ra1);
	end

	// Writes to r0 or to a missing register are dropped
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < REGS; i++)
				regs[i] <= '0;
		end
		else if (we && wa != '0 && wa < REGS)
			regs[wa] <= wd;
	end

endmodule

// File: source/qupls_exec.sv
// Execute slice top with the APB slave, the issue FSM, the register file and the ALU
`timescale 1ns/1ps

module qupls_exec
	import qupls_isa_pkg::*;
	import qupls_bus_pkg::*;
#(
	parameter int REGS = 32
)
(
	input  logic     clk,
	input  logic     rst,
	input  apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	typedef enum logic [1:0] {IDLE, EXEC, WB} state_t;

	state_t       state;
	instruction_t ir_q;
	value_t       result_q;
	value_t       prdata_q;
	logic         pready_q;
	logic         pslverr_q;

	// Address decode
	apb_addr_t reg_off;
	regno_t    reg_idx;
	logic      is_reg;
	logic      is_issue;
	logic      setup;
	logic      access;
	logic      issue_start;
	logic      apb_reg_wr;

	// Register file and ALU hookup
	regno_t ra0;
	regno_t ra1;
	value_t rd0;
	value_t rd1;
	logic   we;
	regno_t wa;
	value_t wd;
	value_t alu_o;
	logic   alu_illegal;

	// ==============================
	// APB decode and port muxing
	// ==============================

	always_comb
	begin
		reg_off  = apb_req.paddr - REG_BASE;
		reg_idx  = reg_off[$bits(regno_t)+1:2];
		// Only word aligned addresses inside the implemented registers count
		is_reg   = (reg_off[1:0] == 2'b00) && (reg_off[11:2] < REGS);
		is_issue = (apb_req.paddr == ISSUE_ADDR);
		setup    = apb_req.psel && !apb_req.penable;
		access   = apb_req.psel && apb_req.penable;
		// First access cycle of an issue write starts the instruction
		issue_start = (state == IDLE) && access && apb_req.pwrite && is_issue;
		apb_reg_wr  = (state == IDLE) && access && apb_req.pwrite && is_reg && pready_q;
		// While busy, port 0 follows rs1 of the latched instruction
		ra0 = (state == IDLE) ? reg_idx : ir_q.r2.rs1;
		ra1 = ir_q.r2.rs2;
		// Issue writeback owns the write port in WB, APB writes use it otherwise
		we = ((state == WB) && !pslverr_q) || apb_reg_wr;
		wa = (state == WB) ? ir_q.r2.rd : reg_idx;
		wd = (state == WB) ? result_q : apb_req.pwdata;
	end

	qupls_regfile #(.REGS(REGS)) u_regfile (
		.clk (clk),
		.rst (rst),
		.ra0 (ra0),
		.ra1 (ra1),
		.rd0 (rd0),
		.rd1 (rd1),
		.we  (we),
		.wa  (wa),
		.wd  (wd)
	);

	qupls_alu u_alu (
		.ir      (ir_q),
		.a       (rd0),
		.rb      (rd1),
		.o       (alu_o),
		.illegal (alu_illegal)
	);

	// ==============================
	// Issue FSM and response
	// ==============================

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state     <= IDLE;
			ir_q      <= '0;
			pready_q  <= 1'b0;
			pslverr_q <= 1'b0;
		end
		else
		begin
			pready_q  <= 1'b0;
			pslverr_q <= 1'b0;
			case (state)
			IDLE:
				begin
					// Everything except an issue write finishes in the first access cycle
					if (setup && !(is_issue && apb_req.pwrite))
					begin
						pready_q  <= 1'b1;
						pslverr_q <= !is_reg && !is_issue;
					end
					if (issue_start)
					begin
						ir_q  <= apb_req.pwdata;
						state <= EXEC;
					end
				end
			EXEC:
				begin
					// The response for the issue goes out in WB, third access cycle
					pready_q  <= 1'b1;
					pslverr_q <= alu_illegal;
					state     <= WB;
				end
			default:
				state <= IDLE;
			endcase
		end
	end

	// Read data is captured with the address during setup
	always_ff @(posedge clk)
	begin
		if (state == IDLE && setup)
			prdata_q <= is_issue ? value_t'(ir_q) : rd0;
		if (state == EXEC)
			result_q <= alu_o;
	end

	assign apb_rsp.pready  = pready_q;
	assign apb_rsp.prdata  = prdata_q;
	assign apb_rsp.pslverr = pslverr_q;

endmodule

// File: verif/qupls_exec_tb.sv
// Testbench for the execute slice with stimulus file reader, APB driver, result checks and watchdog
`timescale 1ns/1ps

module qupls_exec_tb
	import qupls_isa_pkg::*;
	import qupls_bus_pkg::*;
();

	localparam int REGS          = 32;
	localparam int MAX_OPS       = 64;
	localparam int CYCLES_PER_OP = 20;

	// Operation kinds as stored from the stimulus file
	localparam int KIND_WRITE = 0;
	localparam int KIND_READ  = 1;
	localparam int KIND_ISSUE = 2;

	logic     clk;
	logic     rst;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	// One entry per stimulus line
	int        op_kind [MAX_OPS];
	apb_addr_t op_addr [MAX_OPS];
	value_t    op_data [MAX_OPS];
	value_t    op_exp  [MAX_OPS];
	logic      op_err  [MAX_OPS];

	int          n_ops       = 0;
	logic        loaded      = 1'b0;
	// State of the gap generator
	int unsigned lcg_state   = 26;

	qupls_exec #(.REGS(REGS)) u_dut (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp)
	);

	// 4 ns clock period
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ==============================
	// Helpers and checks
	// ==============================

	task automatic stop_on_failure();
		$display("Test failed");
		$fatal(1);
	endtask

	// Classic 32 bit LCG whose upper bits are the more random ones
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input int idx, input value_t got,
		input value_t exp);
		if (got !== exp)
		begin
			$display("Fail %s in operation %0d got 0x%08h expected 0x%08h", name, idx, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_err(input string name, input int idx, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %s in operation %0d got 0x%0h expected 0x%0h", name, idx, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_latency(input string name, input int idx, input int got, input int exp);
		if (got != exp)
		begin
			$display("Fail %s in operation %0d got 0x%0h expected 0x%0h", name, idx, got, exp);
			stop_on_failure();
		end
	endtask

	// Lines starting with a lone # are comments and every other line is one APB operation
	task automatic load_stimulus();
		int           fd;
		int           code;
		logic [63:0]  kind_s;
		logic [1023:0] junk;
		logic [31:0]  f_addr;
		logic [31:0]  f_data;
		logic [31:0]  f_exp;
		logic [31:0]  f_err;
		logic         done;
		fd = $fopen("verif/qupls_exec_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("The stimulus file could not be opened");
			stop_on_failure();
		end
		done = 1'b0;
		while (!done)
		begin
			code = $fscanf(fd, "%s", kind_s);
			if (code != 1)
				done = 1'b1;
			else if (kind_s == "#")
				code = $fgets(junk, fd);
			else
			begin
				code = $fscanf(fd, "%h %h %h %h", f_addr, f_data, f_exp, f_err);
				if (code != 4 || n_ops >= MAX_OPS)
				begin
					$display("Stimulus operation %0d is malformed or one too many", n_ops + 1);
					stop_on_failure();
				end
				if (kind_s == "write")
					op_kind[n_ops] = KIND_WRITE;
				else if (kind_s == "read")
					op_kind[n_ops] = KIND_READ;
				else if (kind_s == "issue")
					op_kind[n_ops] = KIND_ISSUE;
				else
				begin
					$display("Stimulus operation %0d has an unknown kind", n_ops + 1);
					stop_on_failure();
				end
				op_addr[n_ops] = f_addr[11:0];
				op_data[n_ops] = f_data;
				op_exp[n_ops]  = f_exp;
				op_err[n_ops]  = f_err[0];
				n_ops++;
			end
		end
		$fclose(fd);
		if (n_ops == 0)
		begin
			$display("The stimulus file holds no operations");
			stop_on_failure();
		end
	endtask

	// ==============================
	// APB master
	// ==============================

	// Setup and access are driven on rising edges and the response is sampled mid cycle
	task automatic apb_transfer(input logic wr, input apb_addr_t addr, input value_t wdata,
		output value_t rdata, output logic err, output int cycles);
		logic done;
		@(posedge clk);
		apb_req.psel    <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite  <= wr;
		apb_req.paddr   <= addr;
		apb_req.pwdata  <= wdata;
		@(posedge clk);
		apb_req.penable <= 1'b1;
		cycles = 0;
		done   = 1'b0;
		while (!done)
		begin
			@(negedge clk);
			cycles++;
			if (apb_rsp.pready)
			begin
				rdata = apb_rsp.prdata;
				err   = apb_rsp.pslverr;
				done  = 1'b1;
			end
			else
				@(posedge clk);
		end
	endtask

	// Watchdog sized from the number of operations in the file
	initial
	begin
		wait (loaded);
		repeat (CYCLES_PER_OP * n_ops + 10) @(posedge clk);
		$display("The run did not finish in time and was stopped by the watchdog");
		stop_on_failure();
	end

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		value_t rdata;
		logic   err;
		int     cycles;
		int     gap;
		rst     = 1'b1;
		apb_req = '0;
		load_stimulus();
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < n_ops; i++)
		begin
			apb_transfer(op_kind[i] != KIND_READ, op_addr[i], op_data[i], rdata, err, cycles);
			check_err("pslverr", i + 1, err, op_err[i]);
			// Read data only means something on a read that completed without error
			if (op_kind[i] == KIND_READ && !op_err[i])
				check_value("prdata", i + 1, rdata, op_exp[i]);
			// An issue passes IDLE, EXEC and WB while everything else needs no wait state
			check_latency("pready cycle", i + 1, cycles, (op_kind[i] == KIND_ISSUE) ? 3 : 1);
			gap = (lcg_next() >> 16) % 4;
			repeat (gap)
			begin
				@(posedge clk);
				apb_req.psel    <= 1'b0;
				apb_req.penable <= 1'b0;
			end
		end
		@(posedge clk);
		apb_req.psel    <= 1'b0;
		apb_req.penable <= 1'b0;
		$display("Test completed successfully");
		$finish;
	end

endmodule

// File: verif/qupls_exec_stimulus.txt
# kind address(hex) write_data(hex) expected_read_data(hex) expected_pslverr
# Expected read data is compared only on reads that complete without error
write 000 DEADBEEF 00000000 0
read  000 00000000 00000000 0
write 004 FFFFFFF0 00000000 0
write 008 0000000C 00000000 0
write 07C A5A5A5A5 00000000 0
read  004 00000000 FFFFFFF0 0
read  008 00000000 0000000C 0
read  07C 00000000 A5A5A5A5 0
issue 100 01041182 00000000 0
read  00C 00000000 FFFFFFFC 0
issue 100 01422202 00000000 0
read  010 00000000 0000001C 0
issue 100 023E1282 00000000 0
read  014 00000000 A5A5A5A0 0
issue 100 0245F302 00000000 0
read  018 00000000 A5A5A5AD 0
issue 100 0283F382 00000000 0
read  01C 00000000 5A5A5A55 0
issue 100 FFFA2404 00000000 0
read  020 00000000 00000009 0
issue 100 02001484 00000000 0
read  024 00000000 000000F0 0
issue 100 02C41502 00000000 0
read  028 00000000 0000008E 0
issue 100 03041582 00000000 0
read  02C 00000000 00000030 0
issue 100 FFFE260B 00000000 0
read  030 00000000 00000072 0
issue 100 FFFE268C 00000000 0
read  034 00000000 0000000C 0
issue 100 02C42702 00000000 0
read  038 00000000 00000059 0
issue 100 0FC41182 00000000 1
read  00C 00000000 FFFFFFFC 0
issue 100 0000027F 00000000 1
read  010 00000000 0000001C 0
read  100 00000000 0000027F 0
write 084 11111111 00000000 1
read  004 00000000 FFFFFFF0 0
read  080 00000000 00000000 1
read  102 00000000 00000000 1
write 200 22222222 00000000 1

// File: qupls_exec.f
source/qupls_isa_pkg.sv
source/qupls_bus_pkg.sv
source/qupls_cmp.sv
source/qupls_alu.sv
source/qupls_regfile.sv
source/qupls_exec.sv
verif/qupls_exec_tb.sv

// File: Bender.yml
package:
  name: qupls_exec

dependencies: {}

sources:
  # Packages first, the RTL modules depend on them
  - source/qupls_isa_pkg.sv
  - source/qupls_bus_pkg.sv
  # Datapath leaves before the top level
  - source/qupls_cmp.sv
  - source/qupls_alu.sv
  - source/qupls_regfile.sv
  - source/qupls_exec.sv
  # Testbench
  - target: test
    files:
      - verif/qupls_exec_tb.sv
